//--- design/mipsPkg.sv
`default_nettype none

package mipsPkg;

	////////////////////////////////////////////////////////////////////////////
	// basic widths
	////////////////////////////////////////////////////////////////////////////

	typedef logic [4:0] regAddr;
	typedef logic [31:0] word;

	// major opcodes, bits 31:26
	localparam logic [5:0] opRtype = 6'h00;
	localparam logic [5:0] opLw    = 6'h23;
	localparam logic [5:0] opSw    = 6'h2b;
	localparam logic [5:0] opBeq   = 6'h04;
	localparam logic [5:0] opAddi  = 6'h08;

	// r-type function field, bits 5:0
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr  = 6'h25;
	localparam logic [5:0] fnSlt = 6'h2a;

	////////////////////////////////////////////////////////////////////////////
	// control encodings
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOp;

	// operand source for execute
	typedef enum logic [1:0] {
		fwdNone = 2'b00,
		fwdWb   = 2'b01,
		fwdMem  = 2'b10
	} fwdSel;

endpackage

`default_nettype wire

//--- design/hazard.sv
`timescale 1ns/1ps
`default_nettype none

module hazard (
	// decode
	input  mipsPkg::regAddr rsD,
	input  mipsPkg::regAddr rtD,
	input  logic            branchD,
	output logic            forwardAD,
	output logic            forwardBD,
	output logic            stallD,
	// fetch
	output logic            stallF,
	// execute
	input  mipsPkg::regAddr rsE,
	input  mipsPkg::regAddr rtE,
	input  mipsPkg::regAddr writeRegE,
	input  logic            regWriteE,
	input  logic            memToRegE,
	output mipsPkg::fwdSel  forwardAE,
	output mipsPkg::fwdSel  forwardBE,
	output logic            flushE,
	// memory
	input  mipsPkg::regAddr writeRegM,
	input  logic            regWriteM,
	input  logic            memToRegM,
	// writeback
	input  mipsPkg::regAddr writeRegW,
	input  logic            regWriteW
);
	import mipsPkg::*;

	logic loadStall;
	logic branchStall;

	// branch compare only takes the memory-stage alu result
	assign forwardAD = (rsD != 5'd0) && (rsD == writeRegM) && regWriteM;
	assign forwardBD = (rtD != 5'd0) && (rtD == writeRegM) && regWriteM;

	// memory stage is younger, so it wins over writeback
	always_comb begin
		forwardAE = fwdNone;
		forwardBE = fwdNone;
		if (rsE != 5'd0) begin
			if (regWriteM && (rsE == writeRegM)) begin
				forwardAE = fwdMem;
			end else if (regWriteW && (rsE == writeRegW)) begin
				forwardAE = fwdWb;
			end
		end
		if (rtE != 5'd0) begin
			if (regWriteM && (rtE == writeRegM)) begin
				forwardBE = fwdMem;
			end else if (regWriteW && (rtE == writeRegW)) begin
				forwardBE = fwdWb;
			end
		end
	end

	// load in execute, consumer in decode
	assign loadStall = memToRegE && ((rtE == rsD) || (rtE == rtD));

	// beq compares in decode, so the operand has to be ready one stage early
	assign branchStall = branchD &&
		((regWriteE && ((writeRegE == rsD) || (writeRegE == rtD))) ||
		 (memToRegM && ((writeRegM == rsD) || (writeRegM == rtD))));

	// hold fetch and decode, bubble into execute
	assign stallD = loadStall || branchStall;
	assign stallF = stallD;
	assign flushE = stallD;

endmodule

`default_nettype wire

//--- design/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
	input  logic            clk,
	input  logic            arstN,
	input  mipsPkg::word    instrD,
	input  mipsPkg::word    fetchPcD,
	// writeback into the register file
	input  logic            regWriteW,
	input  mipsPkg::regAddr writeRegW,
	input  mipsPkg::word    resultW,
	// branch operand forwarding
	input  mipsPkg::word    aluOutM,
	input  logic            forwardAD,
	input  logic            forwardBD,
	output mipsPkg::regAddr rsD,
	output mipsPkg::regAddr rtD,
	output mipsPkg::regAddr writeRegD,
	output mipsPkg::word    rsDataD,
	output mipsPkg::word    rtDataD,
	output mipsPkg::word    immD,
	output mipsPkg::word    branchTargetD,
	output mipsPkg::aluOp   aluOpD,
	output logic            aluSrcD,
	output logic            regWriteD,
	output logic            memWriteD,
	output logic            memToRegD,
	output logic            branchD,
	output logic            branchTakenD
);
	import mipsPkg::*;

	word    regs [32];
	regAddr rdD;
	regAddr destReg;
	logic   writesReg;
	word    cmpA;
	word    cmpB;

	assign rsD  = instrD[25:21];
	assign rtD  = instrD[20:16];
	assign rdD  = instrD[15:11];
	assign immD = {{16{instrD[15]}}, instrD[15:0]};

	////////////////////////////////////////////////////////////////////////////
	// register file
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (regWriteW && (writeRegW != 5'd0)) begin
			regs[writeRegW] <= resultW;
		end
	end

	// same-cycle writeback bypass, r0 hardwired
	always_comb begin
		rsDataD = regs[rsD];
		rtDataD = regs[rtD];
		if (regWriteW && (writeRegW == rsD)) begin
			rsDataD = resultW;
		end
		if (regWriteW && (writeRegW == rtD)) begin
			rtDataD = resultW;
		end
		if (rsD == 5'd0) begin
			rsDataD = '0;
		end
		if (rtD == 5'd0) begin
			rtDataD = '0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// control decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		aluOpD    = aluAdd;
		aluSrcD   = 1'b0;
		writesReg = 1'b0;
		memWriteD = 1'b0;
		memToRegD = 1'b0;
		branchD   = 1'b0;
		destReg   = rtD;
		case (instrD[31:26])
			opRtype: begin
				destReg   = rdD;
				writesReg = 1'b1;
				case (instrD[5:0])
					fnAdd: aluOpD = aluAdd;
					fnSub: aluOpD = aluSub;
					fnAnd: aluOpD = aluAnd;
					fnOr: aluOpD = aluOr;
					fnSlt: aluOpD = aluSlt;
					// unknown funct, also the all-zero bubble
					default: writesReg = 1'b0;
				endcase
			end
			opLw: begin
				aluSrcD   = 1'b1;
				writesReg = 1'b1;
				memToRegD = 1'b1;
			end
			opSw: begin
				aluSrcD   = 1'b1;
				memWriteD = 1'b1;
			end
			opAddi: begin
				aluSrcD   = 1'b1;
				writesReg = 1'b1;
			end
			opBeq: branchD = 1'b1;
			default: branchD = 1'b0;
		endcase
	end

	// writes to r0 are dropped here
	assign writeRegD = destReg;
	assign regWriteD = writesReg && (destReg != 5'd0);

	// branch resolve
	assign cmpA          = forwardAD ? aluOutM : rsDataD;
	assign cmpB          = forwardBD ? aluOutM : rtDataD;
	assign branchTakenD  = branchD && (cmpA == cmpB);
	assign branchTargetD = fetchPcD + {immD[29:0], 2'b00};

endmodule

`default_nettype wire

//--- design/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
	input  mipsPkg::word   rsDataE,
	input  mipsPkg::word   rtDataE,
	input  mipsPkg::word   immE,
	input  mipsPkg::word   aluOutM,
	input  mipsPkg::word   resultW,
	input  mipsPkg::fwdSel forwardAE,
	input  mipsPkg::fwdSel forwardBE,
	input  mipsPkg::aluOp  aluOpE,
	input  logic           aluSrcE,
	output mipsPkg::word   aluOutE,
	output mipsPkg::word   writeDataE
);
	import mipsPkg::*;

	word srcA;
	word srcB;

	// one operand mux, used for both sides
	function automatic word pickOperand(input fwdSel sel, input word regVal,
		input word memVal, input word wbVal);
		word value;
		case (sel)
			fwdMem: value = memVal;
			fwdWb: value = wbVal;
			default: value = regVal;
		endcase
		return value;
	endfunction

	assign srcA       = pickOperand(forwardAE, rsDataE, aluOutM, resultW);
	assign writeDataE = pickOperand(forwardBE, rtDataE, aluOutM, resultW);

	// immediate for addi, lw, sw
	assign srcB = aluSrcE ? immE : writeDataE;

	////////////////////////////////////////////////////////////////////////////
	// alu
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (aluOpE)
			aluSub: aluOutE = srcA - srcB;
			aluAnd: aluOutE = srcA & srcB;
			aluOr: aluOutE = srcA | srcB;
			// signed compare
			aluSlt: aluOutE = {31'b0, $signed(srcA) < $signed(srcB)};
			default: aluOutE = srcA + srcB;
		endcase
	end

endmodule

`default_nettype wire

//--- design/resultStage.sv
`timescale 1ns/1ps
`default_nettype none

module resultStage #(
	parameter int dataDepth = 64
) (
	input  logic            clk,
	input  logic            arstN,
	input  mipsPkg::word    aluOutM,
	input  mipsPkg::word    writeDataM,
	input  logic            memWriteM,
	input  logic            memToRegM,
	input  logic            regWriteM,
	input  mipsPkg::regAddr writeRegM,
	output mipsPkg::word    resultW,
	output mipsPkg::regAddr writeRegW,
	output logic            regWriteW,
	output logic            memToRegW
);
	import mipsPkg::*;

	localparam int idxBits = $clog2(dataDepth);

	word                dataMem [dataDepth];
	logic [idxBits-1:0] memIdx;
	word                readDataM;
	word                readDataW;
	word                aluOutW;

	// word address, wraps at dataDepth
	assign memIdx    = idxBits'(aluOutM[31:2] % 30'(dataDepth));
	assign readDataM = dataMem[memIdx];

	always_ff @(posedge clk) begin
		if (memWriteM) begin
			dataMem[memIdx] <= writeDataM;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// memory/writeback register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regWriteW <= 1'b0;
			memToRegW <= 1'b0;
		end else begin
			regWriteW <= regWriteM;
			memToRegW <= memToRegM;
		end
	end

	always_ff @(posedge clk) begin
		readDataW <= readDataM;
		aluOutW   <= aluOutM;
		writeRegW <= writeRegM;
	end

	// load data or alu result
	assign resultW = memToRegW ? readDataW : aluOutW;

endmodule

`default_nettype wire

//--- design/pipeCore.sv
`timescale 1ns/1ps
`default_nettype none

module pipeCore #(
	parameter int dataDepth = 64
) (
	input  logic            clk,
	input  logic            arstN,
	input  mipsPkg::word    instr,
	output mipsPkg::word    pc,
	output mipsPkg::word    wbData,
	output mipsPkg::regAddr wbReg,
	output logic            wbValid
);
	import mipsPkg::*;

	// decode
	word    instrD;
	word    fetchPcD;
	word    rsDataD;
	word    rtDataD;
	word    immD;
	word    branchTargetD;
	regAddr rsD;
	regAddr rtD;
	regAddr writeRegD;
	aluOp   aluOpD;
	logic   aluSrcD;
	logic   regWriteD;
	logic   memWriteD;
	logic   memToRegD;
	logic   branchD;
	logic   branchTakenD;
	logic   forwardAD;
	logic   forwardBD;
	// execute
	word    rsDataE;
	word    rtDataE;
	word    immE;
	word    aluOutE;
	word    writeDataE;
	regAddr rsE;
	regAddr rtE;
	regAddr writeRegE;
	aluOp   aluOpE;
	logic   aluSrcE;
	logic   regWriteE;
	logic   memWriteE;
	logic   memToRegE;
	fwdSel  forwardAE;
	fwdSel  forwardBE;
	// memory and writeback
	word    aluOutM;
	word    writeDataM;
	word    resultW;
	regAddr writeRegM;
	regAddr writeRegW;
	logic   regWriteM;
	logic   memWriteM;
	logic   memToRegM;
	logic   regWriteW;
	logic   stallF;
	logic   stallD;
	logic   flushE;

	////////////////////////////////////////////////////////////////////////////
	// fetch and fetch/decode register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else if (!stallF) begin
			pc <= branchTakenD ? branchTargetD : pc + 32'd4;
		end
	end

	// a taken branch squashes the instruction behind it
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			instrD   <= '0;
			fetchPcD <= '0;
		end else if (!stallD) begin
			instrD   <= branchTakenD ? '0 : instr;
			fetchPcD <= pc + 32'd4;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// decode/execute register
	////////////////////////////////////////////////////////////////////////////

	// control bits go low on flush to form a bubble
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regWriteE <= 1'b0;
			memWriteE <= 1'b0;
			memToRegE <= 1'b0;
		end else if (flushE) begin
			regWriteE <= 1'b0;
			memWriteE <= 1'b0;
			memToRegE <= 1'b0;
		end else begin
			regWriteE <= regWriteD;
			memWriteE <= memWriteD;
			memToRegE <= memToRegD;
		end
	end

	// payload of a bubble is never written anywhere
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rsDataE   <= '0;
			rtDataE   <= '0;
			immE      <= '0;
			rsE       <= '0;
			rtE       <= '0;
			writeRegE <= '0;
			aluOpE    <= aluAdd;
			aluSrcE   <= 1'b0;
		end else begin
			rsDataE   <= rsDataD;
			rtDataE   <= rtDataD;
			immE      <= immD;
			rsE       <= rsD;
			rtE       <= rtD;
			writeRegE <= writeRegD;
			aluOpE    <= aluOpD;
			aluSrcE   <= aluSrcD;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// execute/memory register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			aluOutM    <= '0;
			writeDataM <= '0;
			writeRegM  <= '0;
			regWriteM  <= 1'b0;
			memWriteM  <= 1'b0;
			memToRegM  <= 1'b0;
		end else begin
			aluOutM    <= aluOutE;
			writeDataM <= writeDataE;
			writeRegM  <= writeRegE;
			regWriteM  <= regWriteE;
			memWriteM  <= memWriteE;
			memToRegM  <= memToRegE;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stages
	////////////////////////////////////////////////////////////////////////////

	hazard uHazard (
		.rsD(rsD),
		.rtD(rtD),
		.branchD(branchD),
		.forwardAD(forwardAD),
		.forwardBD(forwardBD),
		.stallD(stallD),
		.stallF(stallF),
		.rsE(rsE),
		.rtE(rtE),
		.writeRegE(writeRegE),
		.regWriteE(regWriteE),
		.memToRegE(memToRegE),
		.forwardAE(forwardAE),
		.forwardBE(forwardBE),
		.flushE(flushE),
		.writeRegM(writeRegM),
		.regWriteM(regWriteM),
		.memToRegM(memToRegM),
		.writeRegW(writeRegW),
		.regWriteW(regWriteW)
	);

	decodeStage uDecode (
		.clk(clk),
		.arstN(arstN),
		.instrD(instrD),
		.fetchPcD(fetchPcD),
		.regWriteW(regWriteW),
		.writeRegW(writeRegW),
		.resultW(resultW),
		.aluOutM(aluOutM),
		.forwardAD(forwardAD),
		.forwardBD(forwardBD),
		.rsD(rsD),
		.rtD(rtD),
		.writeRegD(writeRegD),
		.rsDataD(rsDataD),
		.rtDataD(rtDataD),
		.immD(immD),
		.branchTargetD(branchTargetD),
		.aluOpD(aluOpD),
		.aluSrcD(aluSrcD),
		.regWriteD(regWriteD),
		.memWriteD(memWriteD),
		.memToRegD(memToRegD),
		.branchD(branchD),
		.branchTakenD(branchTakenD)
	);

	executeStage uExecute (
		.rsDataE(rsDataE),
		.rtDataE(rtDataE),
		.immE(immE),
		.aluOutM(aluOutM),
		.resultW(resultW),
		.forwardAE(forwardAE),
		.forwardBE(forwardBE),
		.aluOpE(aluOpE),
		.aluSrcE(aluSrcE),
		.aluOutE(aluOutE),
		.writeDataE(writeDataE)
	);

	resultStage #(.dataDepth(dataDepth)) uResult (
		.clk(clk),
		.arstN(arstN),
		.aluOutM(aluOutM),
		.writeDataM(writeDataM),
		.memWriteM(memWriteM),
		.memToRegM(memToRegM),
		.regWriteM(regWriteM),
		.writeRegM(writeRegM),
		.resultW(resultW),
		.writeRegW(writeRegW),
		.regWriteW(regWriteW),
		.memToRegW()
	);

	// retired writes, r0 never gets here
	assign wbValid = regWriteW;
	assign wbReg   = writeRegW;
	assign wbData  = resultW;

endmodule

`default_nettype wire

//--- tb/pipeCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module pipeCoreTb;
	import mipsPkg::*;

	localparam int numTests  = 6;
	localparam int waitLimit = 200;

	logic        clk;
	logic        arstN;
	word         instr;
	word         pc;
	word         wbData;
	regAddr      wbReg;
	logic        wbValid;

	// instruction memory, word index from pc
	word         imem [256];

	// all tests packed into flat tables, sliced by base and length
	string       testName [numTests];
	word         progRom [256];
	int          progBase [numTests];
	int          progLen [numTests];
	regAddr      expReg [128];
	word         expVal [128];
	int          expBase [numTests];
	int          expLen [numTests];
	int          progFill;
	int          expFill;

	int          mismatchCount;
	int          timeoutCount;
	int          extraCount;
	logic [31:0] rngState;

	pipeCore #(.dataDepth(64)) u_dut (
		.clk(clk),
		.arstN(arstN),
		.instr(instr),
		.pc(pc),
		.wbData(wbData),
		.wbReg(wbReg),
		.wbValid(wbValid)
	);

	// combinational fetch
	assign instr = imem[pc[9:2]];

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// instruction encoders and random source
	////////////////////////////////////////////////////////////////////////////

	function automatic word rType(input logic [5:0] fn, input int rd, input int rs,
		input int rt);
		return {opRtype, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	// asm order is op rt, rs, imm
	function automatic word iType(input logic [5:0] op, input int rt, input int rs,
		input int imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// table building
	////////////////////////////////////////////////////////////////////////////

	// r of 0 means no retired write is expected
	task automatic addStep(input word w, input int r, input word v);
		progRom[progFill] = w;
		progFill++;
		if (r != 0) begin
			expReg[expFill] = 5'(r);
			expVal[expFill] = v;
			expFill++;
		end
	endtask

	task automatic openTest(input int t, input string name);
		testName[t] = name;
		progBase[t] = progFill;
		expBase[t]  = expFill;
	endtask

	// beq r0, r0, -1 spins in place
	task automatic closeTest(input int t);
		addStep(iType(opBeq, 0, 0, -1), 0, '0);
		progLen[t] = progFill - progBase[t];
		expLen[t]  = expFill - expBase[t];
	endtask

	task automatic buildTables();
		word         acc;
		logic [15:0] imm;
		progFill = 0;
		expFill  = 0;
		// dependent alu ops, mem and wb forwarding
		openTest(0, "alu forwarding");
		addStep(iType(opAddi, 1, 0, 5), 1, 32'd5);
		addStep(iType(opAddi, 2, 0, 3), 2, 32'd3);
		addStep(rType(fnAdd, 3, 1, 2), 3, 32'd8);
		addStep(rType(fnSub, 4, 3, 1), 4, 32'd3);
		addStep(rType(fnAnd, 5, 4, 3), 5, 32'd0);
		addStep(rType(fnOr, 6, 5, 4), 6, 32'd3);
		addStep(rType(fnSlt, 7, 2, 3), 7, 32'd1);
		addStep(iType(opAddi, 8, 0, 1), 8, 32'd1);
		addStep(iType(opAddi, 8, 8, 2), 8, 32'd3);
		// r8 sits in both mem and wb here so mem must win
		addStep(rType(fnAdd, 9, 8, 8), 9, 32'd6);
		closeTest(0);
		openTest(1, "load use");
		addStep(iType(opAddi, 1, 0, 77), 1, 32'd77);
		addStep(iType(opSw, 1, 0, 8), 0, '0);
		addStep(iType(opLw, 2, 0, 8), 2, 32'd77);
		addStep(rType(fnAdd, 3, 2, 1), 3, 32'd154);
		closeTest(1);
		// skipped instructions carry no expected write
		openTest(2, "branch");
		addStep(iType(opAddi, 1, 0, 4), 1, 32'd4);
		addStep(iType(opAddi, 2, 0, 4), 2, 32'd4);
		addStep(iType(opBeq, 2, 1, 1), 0, '0);
		addStep(iType(opAddi, 3, 0, 99), 0, '0);
		addStep(iType(opAddi, 4, 0, 7), 4, 32'd7);
		addStep(iType(opBeq, 1, 4, 1), 0, '0);
		addStep(iType(opAddi, 5, 0, 11), 5, 32'd11);
		addStep(iType(opSw, 4, 0, 12), 0, '0);
		addStep(iType(opLw, 6, 0, 12), 6, 32'd7);
		addStep(iType(opBeq, 4, 6, 1), 0, '0);
		addStep(iType(opAddi, 7, 0, 55), 0, '0);
		addStep(iType(opLw, 8, 0, 12), 8, 32'd7);
		addStep(iType(opBeq, 1, 8, 1), 0, '0);
		addStep(iType(opAddi, 9, 0, 66), 9, 32'd66);
		closeTest(2);
		openTest(3, "store load");
		addStep(iType(opAddi, 1, 0, 16'h1234), 1, 32'h1234);
		addStep(iType(opAddi, 2, 0, -9), 2, 32'hffff_fff7);
		addStep(iType(opSw, 1, 0, 16), 0, '0);
		addStep(iType(opSw, 2, 0, 20), 0, '0);
		addStep(iType(opLw, 3, 0, 16), 3, 32'h1234);
		addStep(iType(opLw, 4, 0, 20), 4, 32'hffff_fff7);
		closeTest(3);
		// r0 never retires and never forwards
		openTest(4, "register zero");
		addStep(iType(opAddi, 0, 0, 5), 0, '0);
		addStep(rType(fnAdd, 1, 0, 0), 1, 32'd0);
		addStep(iType(opAddi, 0, 0, 9), 0, '0);
		addStep(iType(opAddi, 2, 0, 3), 2, 32'd3);
		// would give 15 in r0 if the write were kept
		addStep(iType(opAddi, 0, 2, 12), 0, '0);
		addStep(rType(fnOr, 3, 0, 2), 3, 32'd3);
		closeTest(4);
		// running sum of sign-extended immediates with 32-bit wrap
		openTest(5, "addi chain");
		acc = '0;
		for (int k = 0; k < 12; k++) begin
			rngState = xorshift(rngState);
			imm      = rngState[15:0];
			acc      = acc + {{16{imm[15]}}, imm};
			addStep(iType(opAddi, 1, (k == 0) ? 0 : 1, int'(imm)), 1, acc);
		end
		closeTest(5);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// checking
	////////////////////////////////////////////////////////////////////////////

	task automatic checkValue(input string what, input word expected, input word actual);
		if (expected !== actual) begin
			$display("Error %s: expected %h, actual %h", what, expected, actual);
			mismatchCount++;
		end
	endtask

	task automatic runTest(input int t);
		int cyc;
		bit seen;
		bit lost;
		@(posedge clk);
		arstN <= 1'b0;
		// unused words hold a non-writing r-type tagged with the address
		for (int i = 0; i < 256; i++) begin
			imem[i] <= {opRtype, 20'(i), 6'h3f};
		end
		for (int i = 0; i < progLen[t]; i++) begin
			imem[i] <= progRom[progBase[t] + i];
		end
		repeat (3) @(posedge clk);
		arstN <= 1'b1;
		lost = 1'b0;
		for (int k = 0; k < expLen[t] && !lost; k++) begin
			seen = 1'b0;
			cyc  = 0;
			// wbValid is sampled on the falling edge
			while (!seen && cyc < waitLimit) begin
				@(negedge clk);
				seen = (wbValid === 1'b1);
				cyc++;
			end
			if (seen) begin
				checkValue($sformatf("%s write %0d reg", testName[t], k),
					32'(expReg[expBase[t] + k]), 32'(wbReg));
				checkValue($sformatf("%s write %0d data", testName[t], k),
					expVal[expBase[t] + k], wbData);
			end else begin
				$display("%s: write %0d to r%0d never arrived", testName[t], k,
					expReg[expBase[t] + k]);
				timeoutCount++;
				lost = 1'b1;
			end
		end
		// core should now spin without retiring anything
		if (!lost) begin
			for (int i = 0; i < 40; i++) begin
				@(negedge clk);
				if (wbValid !== 1'b0) begin
					$display("%s: unexpected write of %h to r%0d", testName[t], wbData, wbReg);
					extraCount++;
				end
			end
		end
	endtask

	initial begin
		arstN         = 1'b0;
		mismatchCount = 0;
		timeoutCount  = 0;
		extraCount    = 0;
		rngState      = 32'h736e;
		buildTables();
		for (int t = 0; t < numTests; t++) begin
			runTest(t);
		end
		$display("mismatches %0d, timeouts %0d, extra writes %0d", mismatchCount,
			timeoutCount, extraCount);
		if (mismatchCount + timeoutCount + extraCount == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
design/mipsPkg.sv
design/hazard.sv
design/decodeStage.sv
design/executeStage.sv
design/resultStage.sv
design/pipeCore.sv
tb/pipeCoreTb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = pipeCoreTb
FILELIST  = vlog.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
